//--- logic/rename_config.svh
// sizing macros for the rename stage, included by rename_pkg and the testbench
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file as seen by software
`define RENAME_ARCH_REGS 32

// physical register file behind the rename map
`define RENAME_PHYS_REGS 64

// one checkpoint per ROB entry, indexed by the ROB tail
`define RENAME_CKPT_SLOTS 16

`endif

//--- logic/rename_pkg.sv
// shared types and derived sizes for the rename stage; import inside module bodies
package rename_pkg;

  `include "rename_config.svh"

  // base sizes pulled from the config header
  localparam int ARCH_REGS  = `RENAME_ARCH_REGS;   // r0..r31
  localparam int PHYS_REGS  = `RENAME_PHYS_REGS;   // p0..p63
  localparam int CKPT_SLOTS = `RENAME_CKPT_SLOTS;  // one per rob entry

  // regs left over once every arch reg owns one
  localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

  // field widths
  localparam int ARCH_W  = $clog2(ARCH_REGS);       // 5
  localparam int PHYS_W  = $clog2(PHYS_REGS);       // 6
  localparam int CKPT_W  = $clog2(CKPT_SLOTS);      // 4
  localparam int COUNT_W = $clog2(FREE_DEPTH) + 1;  // holds 0..32

  // architectural register index
  typedef logic [ARCH_W-1:0] arch_idx_t;

  // physical register tag
  typedef logic [PHYS_W-1:0] phys_tag_t;

  // checkpoint slot, same as the rob index
  typedef logic [CKPT_W-1:0] ckpt_idx_t;

  // number of tags sitting in the free queue
  typedef logic [COUNT_W-1:0] free_count_t;

  // result of a map lookup, tag plus its ready bit
  typedef struct packed {
    phys_tag_t tag;    // current physical mapping
    logic      ready;  // value already on the cdb
  } map_entry_t;

endpackage

//--- logic/map_port_if.sv
// lookup and write bus between rename_dispatch and map_table
interface map_port_if;
  import rename_pkg::*;

  // driven by the dispatch side
  arch_idx_t  reg_dest;  // destination being renamed
  arch_idx_t  reg_a;     // first source
  arch_idx_t  reg_b;     // second source
  logic       write;     // map reg_dest to new_tag this edge
  phys_tag_t  new_tag;   // tag taken from the free list

  // driven by the table side, combinational from registered state
  phys_tag_t  old_tag;   // prior mapping of reg_dest
  map_entry_t src_a;     // mapping of reg_a
  map_entry_t src_b;     // mapping of reg_b

  modport requester (
    output reg_dest, reg_a, reg_b, write, new_tag,
    input  old_tag, src_a, src_b
  );

  // table is a reserved word, hence the short name
  modport tbl (
    input  reg_dest, reg_a, reg_b, write, new_tag,
    output old_tag, src_a, src_b
  );

endinterface

//--- logic/map_table.sv
// arch-to-phys rename map with ready bits and per-rob checkpoints for branch rollback
module map_table (
  input  logic                  clock,
  input  logic                  reset,
  map_port_if.tbl               map,
  input  rename_pkg::ckpt_idx_t rob_tail,
  input  logic                  cdb_valid,
  input  rename_pkg::phys_tag_t cdb_tag,
  input  logic                  rollback_valid,
  input  rename_pkg::ckpt_idx_t rollback_tag
);
  import rename_pkg::*;

  phys_tag_t [ARCH_REGS-1:0] map_q;                // live mapping
  phys_tag_t [ARCH_REGS-1:0] map_wr;               // mapping after this cycle's write
  phys_tag_t [ARCH_REGS-1:0] ckpt_q [CKPT_SLOTS];  // saved maps, one per rob slot
  logic      [PHYS_REGS-1:0] ready_q;              // indexed by physical tag

  phys_tag_t tag_a;  // looked-up tags, reused for ready lookup
  phys_tag_t tag_b;

  // map as it stands once the dispatch write is applied
  always_comb begin
    map_wr               = map_q;
    map_wr[map.reg_dest] = map.new_tag;  // r0 never arrives here with write set
  end

  // source and old-dest lookups, no cdb bypass
  always_comb begin
    tag_a       = map_q[map.reg_a];
    tag_b       = map_q[map.reg_b];
    map.old_tag = map_q[map.reg_dest];  // goes to the rob as t_old
    map.src_a   = map_entry_t'{tag: tag_a, ready: ready_q[tag_a]};
    map.src_b   = map_entry_t'{tag: tag_b, ready: ready_q[tag_b]};
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= phys_tag_t'(i);  // r_i starts on p_i
        for (int s = 0; s < CKPT_SLOTS; s++) begin
          ckpt_q[s][i] <= phys_tag_t'(i);  // every slot starts as the reset map
        end
      end
      ready_q <= '1;  // all values committed at reset
    end else begin
      if (rollback_valid) begin
        map_q <= ckpt_q[rollback_tag];  // ready bits stay, they follow phys regs
      end else if (map.write) begin
        map_q            <= map_wr;
        ckpt_q[rob_tail] <= map_wr;     // snapshot includes this dispatch
        ready_q[map.new_tag] <= 1'b0;   // result not produced yet
      end
      // cdb after the write clear, also honoured during rollback
      if (cdb_valid) begin
        ready_q[cdb_tag] <= 1'b1;  // every reg mapped to it reads ready
      end
    end
  end

endmodule

//--- logic/free_list.sv
// circular queue of free physical tags, popped at dispatch and pushed at retire
module free_list (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    alloc,
  output rename_pkg::phys_tag_t   head_tag,
  output logic                    empty,
  output rename_pkg::free_count_t free_count,
  input  logic                    retire_valid,
  input  rename_pkg::phys_tag_t   retire_told,
  input  rename_pkg::ckpt_idx_t   rob_tail,
  input  logic                    rollback_valid,
  input  rename_pkg::ckpt_idx_t   rollback_tag
);
  import rename_pkg::*;

  localparam int IDX_W = $clog2(FREE_DEPTH);  // slot index bits

  // extra msb is the wrap bit, so full and empty differ
  typedef logic [IDX_W:0] ptr_t;

  phys_tag_t fifo_q [FREE_DEPTH];       // tag storage
  ptr_t      head_q;                    // next tag to hand out
  ptr_t      tail_q;                    // next slot for a retired tag
  ptr_t      head_inc;                  // head after a pop
  ptr_t      ckpt_head_q [CKPT_SLOTS];  // head saved per rob slot

  assign head_inc   = head_q + 1'b1;
  assign head_tag   = fifo_q[head_q[IDX_W-1:0]];  // valid only when not empty
  assign free_count = free_count_t'(tail_q - head_q);
  assign empty      = (free_count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
      tail_q <= ptr_t'(FREE_DEPTH);  // queue starts full
      for (int i = 0; i < FREE_DEPTH; i++) begin
        fifo_q[i] <= phys_tag_t'(ARCH_REGS + i);  // p32..p63 in order
      end
      for (int s = 0; s < CKPT_SLOTS; s++) begin
        ckpt_head_q[s] <= '0;  // matches the reset head
      end
    end else begin
      if (rollback_valid) begin
        // tags handed out after the checkpoint become free again
        head_q <= ckpt_head_q[rollback_tag];
      end else if (alloc) begin
        head_q                <= head_inc;
        ckpt_head_q[rob_tail] <= head_inc;  // post-pop head for this branch
      end
      // retire still pushes in a rollback cycle
      if (retire_valid) begin
        fifo_q[tail_q[IDX_W-1:0]] <= retire_told;
        tail_q                    <= tail_q + 1'b1;
      end
    end
  end

endmodule

//--- logic/rename_dispatch.sv
// stall and allocate decision for one dispatch, forms t_new/t_old and the source tags
module rename_dispatch (
  input  logic                  dispatch_valid,
  input  rename_pkg::arch_idx_t reg_dest,
  input  rename_pkg::arch_idx_t reg_a,
  input  rename_pkg::arch_idx_t reg_b,
  input  logic                  rollback_valid,
  input  logic                  empty,
  input  rename_pkg::phys_tag_t head_tag,
  output logic                  alloc,
  map_port_if.requester         map,
  output logic                  stall,
  output rename_pkg::phys_tag_t t_new,
  output rename_pkg::phys_tag_t t_old,
  output rename_pkg::phys_tag_t t1,
  output rename_pkg::phys_tag_t t2,
  output logic                  t1_ready,
  output logic                  t2_ready
);
  import rename_pkg::*;

  logic dest_live;  // dest needs a fresh tag
  logic go;         // dispatch actually renames this cycle

  assign dest_live = (reg_dest != arch_idx_t'(0));  // r0 is pinned to p0

  // structural hazard only, upstream holds its fields while high
  assign stall = dispatch_valid && dest_live && empty;

  // rollback beats dispatch, nothing gets allocated
  assign go = dispatch_valid && !stall && !rollback_valid && dest_live;

  assign alloc = go;  // pops head_tag at the edge

  // lookup side of the map bus
  assign map.reg_dest = reg_dest;
  assign map.reg_a    = reg_a;
  assign map.reg_b    = reg_b;
  assign map.write    = go;
  assign map.new_tag  = head_tag;

  // p0 whenever no tag is taken
  assign t_new = go ? head_tag : phys_tag_t'(0);

  // old mapping goes to the rob for freeing at retire
  assign t_old = map.old_tag;

  // source operands for the reservation station
  assign t1       = map.src_a.tag;
  assign t1_ready = map.src_a.ready;
  assign t2       = map.src_b.tag;
  assign t2_ready = map.src_b.ready;

endmodule

//--- logic/rename_stage.sv
// rename stage top, joins map_table, free_list and rename_dispatch to plain ports
module rename_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch_valid,
  input  rename_pkg::arch_idx_t   reg_dest,
  input  rename_pkg::arch_idx_t   reg_a,
  input  rename_pkg::arch_idx_t   reg_b,
  input  rename_pkg::ckpt_idx_t   rob_tail,
  input  logic                    cdb_valid,
  input  rename_pkg::phys_tag_t   cdb_tag,
  input  logic                    retire_valid,
  input  rename_pkg::phys_tag_t   retire_told,
  input  logic                    rollback_valid,
  input  rename_pkg::ckpt_idx_t   rollback_tag,
  output logic                    stall,
  output rename_pkg::phys_tag_t   t_new,
  output rename_pkg::phys_tag_t   t_old,
  output rename_pkg::phys_tag_t   t1,
  output logic                    t1_ready,
  output rename_pkg::phys_tag_t   t2,
  output logic                    t2_ready,
  output rename_pkg::free_count_t free_count
);
  import rename_pkg::*;

  logic      alloc;     // pop strobe to the free list
  logic      empty;     // no free tag left
  phys_tag_t head_tag;  // tag offered to the next dispatch

  map_port_if map_bus ();  // dispatch to map table

  map_table map_table_inst (
    .clock          (clock),
    .reset          (reset),
    .map            (map_bus.tbl),
    .rob_tail       (rob_tail),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .rollback_valid (rollback_valid),
    .rollback_tag   (rollback_tag)
  );

  free_list free_list_inst (
    .clock          (clock),
    .reset          (reset),
    .alloc          (alloc),
    .head_tag       (head_tag),
    .empty          (empty),
    .free_count     (free_count),
    .retire_valid   (retire_valid),
    .retire_told    (retire_told),
    .rob_tail       (rob_tail),
    .rollback_valid (rollback_valid),
    .rollback_tag   (rollback_tag)
  );

  rename_dispatch rename_dispatch_inst (
    .dispatch_valid (dispatch_valid),
    .reg_dest       (reg_dest),
    .reg_a          (reg_a),
    .reg_b          (reg_b),
    .rollback_valid (rollback_valid),
    .empty          (empty),
    .head_tag       (head_tag),
    .alloc          (alloc),
    .map            (map_bus.requester),
    .stall          (stall),
    .t_new          (t_new),
    .t_old          (t_old),
    .t1             (t1),
    .t2             (t2),
    .t1_ready       (t1_ready),
    .t2_ready       (t2_ready)
  );

endmodule

//--- dv/rename_stage_checker.sv
// concurrent assertions on rename_stage outputs that the testbench binds into the top level
module rename_stage_checker (
  input logic                    clock,
  input logic                    reset,
  input logic                    dispatch_valid,
  input rename_pkg::arch_idx_t   reg_dest,
  input rename_pkg::arch_idx_t   reg_a,
  input rename_pkg::arch_idx_t   reg_b,
  input logic                    rollback_valid,
  input logic                    retire_valid,
  input logic                    stall,
  input rename_pkg::phys_tag_t   t_new,
  input rename_pkg::phys_tag_t   t1,
  input logic                    t1_ready,
  input rename_pkg::phys_tag_t   t2,
  input logic                    t2_ready,
  input rename_pkg::free_count_t free_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import rename_pkg::*;

  int fails = 0;  // failed assertions so far

  // after a stall only a retire can refill the empty list
  stall_pops_nothing: assert property (@(posedge clock) disable iff (reset)
    (stall && !rollback_valid) |=> free_count == free_count_t'($past(retire_valid)))
    else begin
      fails++;
      $error("free_count after a stall differs from the retire count");
    end

  count_in_range: assert property (@(posedge clock) disable iff (reset)
    free_count <= free_count_t'(FREE_DEPTH))
    else begin
      fails++;
      $error("free_count above the free queue depth");
    end

  // a real rename must hand out a real tag
  alloc_not_p0: assert property (@(posedge clock) disable iff (reset)
    (dispatch_valid && reg_dest != '0 && !stall && !rollback_valid) |-> t_new != '0)
    else begin
      fails++;
      $error("dispatch went ahead with t_new p0");
    end

  src_a_r0: assert property (@(posedge clock) disable iff (reset)
    (reg_a == '0) |-> (t1 == '0 && t1_ready))
    else begin
      fails++;
      $error("r0 on source a not read as p0 ready");
    end

  src_b_r0: assert property (@(posedge clock) disable iff (reset)
    (reg_b == '0) |-> (t2 == '0 && t2_ready))
    else begin
      fails++;
      $error("r0 on source b not read as p0 ready");
    end

endmodule

//--- dv/rename_stage_tb.sv
// directed testbench for rename_stage that applies a table of steps and checks every output
`include "rename_config.svh"

module rename_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rename_pkg::*;

  localparam int FREE_AT_RESET = `RENAME_PHYS_REGS - `RENAME_ARCH_REGS;  // 32 spare tags

  // stimulus in 0..10 and expected outputs in 11..18
  typedef int row_t [19];

  logic        clock = 1'b0;
  logic        reset;
  logic        dispatch_valid;
  arch_idx_t   reg_dest;
  arch_idx_t   reg_a;
  arch_idx_t   reg_b;
  ckpt_idx_t   rob_tail;
  logic        cdb_valid;
  phys_tag_t   cdb_tag;
  logic        retire_valid;
  phys_tag_t   retire_told;
  logic        rollback_valid;
  ckpt_idx_t   rollback_tag;
  logic        stall;
  phys_tag_t   t_new;
  phys_tag_t   t_old;
  phys_tag_t   t1;
  logic        t1_ready;
  phys_tag_t   t2;
  logic        t2_ready;
  free_count_t free_count;

  row_t steps [$];     // the step table
  int   cycles = 0;    // watchdog count
  int   checks = 0;
  int   errors = 0;
  int   step_errs;     // mismatches in the current step

  always #20 clock = ~clock;  // 40 ns period

  rename_stage rename_stage_inst (.*);

  bind rename_stage rename_stage_checker checker_inst (
    .clock(clock), .reset(reset), .dispatch_valid(dispatch_valid), .reg_dest(reg_dest),
    .reg_a(reg_a), .reg_b(reg_b), .rollback_valid(rollback_valid),
    .retire_valid(retire_valid), .stall(stall),
    .t_new(t_new), .t1(t1), .t1_ready(t1_ready), .t2(t2), .t2_ready(t2_ready),
    .free_count(free_count)
  );

  // column order dv dest a b tail | cdb_v cdb_tag | ret_v told | rb_v rb_tag |
  //   stall t_new t_old t1 t1_rdy t2 t2_rdy free_count
  task automatic build_table();
    int prev;  // old mapping of r6 during the drain
    steps.push_back('{0, 0, 5,31,0, 0, 0, 0,0, 0,0,  0, 0, 0, 5,1,31,1,32});  // reset map
    steps.push_back('{0, 0, 0,17,0, 0, 0, 0,0, 0,0,  0, 0, 0, 0,1,17,1,32});  // r0 is p0
    steps.push_back('{1, 1, 2, 3,0, 0, 0, 0,0, 0,0,  0,32, 1, 2,1, 3,1,32});  // first alloc
    steps.push_back('{1, 2, 1, 1,1, 0, 0, 0,0, 0,0,  0,33, 2,32,0,32,0,31});  // r1 not ready
    steps.push_back('{1, 0, 2, 0,2, 0, 0, 0,0, 0,0,  0, 0, 0,33,0, 0,1,30});  // r0 dest pops nothing
    steps.push_back('{0, 0, 1, 2,0, 1,32, 0,0, 0,0,  0, 0, 0,32,0,33,0,30});  // cdb p32
    steps.push_back('{0, 0, 1, 2,0, 0, 0, 0,0, 0,0,  0, 0, 0,32,1,33,0,30});  // p32 now ready
    steps.push_back('{1, 3, 1, 0,3, 0, 0, 0,0, 0,0,  0,34, 3,32,1, 0,1,30});  // ckpt slot 3
    steps.push_back('{1, 1, 3, 2,4, 0, 0, 0,0, 0,0,  0,35,32,34,0,33,0,29});  // ckpt slot 4
    steps.push_back('{1, 4, 1, 4,5, 0, 0, 0,0, 0,0,  0,36, 4,35,0, 4,1,28});
    steps.push_back('{1, 5, 1, 4,6, 1,34, 0,0, 1,3,  0, 0, 5,35,0,36,0,27});  // rollback wins
    steps.push_back('{0, 0, 1, 3,0, 0, 0, 0,0, 0,0,  0, 0, 0,32,1,34,1,29});  // restored map
    steps.push_back('{0, 0, 4, 2,0, 0, 0, 0,0, 0,0,  0, 0, 0, 4,1,33,0,29});
    steps.push_back('{1, 5, 0, 0,4, 0, 0, 0,0, 0,0,  0,35, 5, 0,1, 0,1,29});  // p35 reused
    // drain the 28 remaining tags p36..p63 through r6
    for (int i = 0; i < FREE_AT_RESET - 4; i++) begin
      prev = (i == 0) ? 6 : 35 + i;
      steps.push_back('{1, 6, 6, 5,7, 0, 0, 0,0, 0,0,
                        0, 36 + i, prev, prev, (i == 0) ? 1 : 0, 35, 0, 28 - i});
    end
    steps.push_back('{1, 7, 6, 0,8, 0, 0, 1,7, 0,0,  1, 0, 7,63,0, 0,1, 0});  // stall while p7 retires
    steps.push_back('{1, 7, 6, 0,8, 0, 0, 0,0, 0,0,  0, 7, 7,63,0, 0,1, 1});  // gets p7 back
    steps.push_back('{0, 0, 7, 6,0, 0, 0, 0,0, 0,0,  0, 0, 0, 7,0,63,0, 0});
    steps.push_back('{1, 0, 0, 7,0, 0, 0, 0,0, 0,0,  0, 0, 0, 0,1, 7,0, 0});  // r0 never stalls
  endtask

  task automatic apply_row(input row_t r);
    dispatch_valid <= r[0];
    reg_dest       <= arch_idx_t'(r[1]);
    reg_a          <= arch_idx_t'(r[2]);
    reg_b          <= arch_idx_t'(r[3]);
    rob_tail       <= ckpt_idx_t'(r[4]);
    cdb_valid      <= r[5];
    cdb_tag        <= phys_tag_t'(r[6]);
    retire_valid   <= r[7];
    retire_told    <= phys_tag_t'(r[8]);
    rollback_valid <= r[9];
    rollback_tag   <= ckpt_idx_t'(r[10]);
  endtask

  task automatic compare_out(input string name, input int got, input int want);
    checks++;
    if (got != want) begin
      errors++;
      step_errs++;
      $display("error at %0d ns: %s is %0d, expected %0d", $time, name, got, want);
    end
  endtask

  task automatic check_row(input row_t r);
    compare_out("stall", int'(stall), r[11]);
    compare_out("t_new", int'(t_new), r[12]);
    compare_out("t_old", int'(t_old), r[13]);
    compare_out("t1", int'(t1), r[14]);
    compare_out("t1_ready", int'(t1_ready), r[15]);
    compare_out("t2", int'(t2), r[16]);
    compare_out("t2_ready", int'(t2_ready), r[17]);
    compare_out("free_count", int'(free_count), r[18]);
  endtask

  // watchdog allows four cycles per step plus slack for reset
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= 4 * steps.size() + 20) begin
      $display("run did not finish within %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    reg_dest       = '0;
    reg_a          = '0;
    reg_b          = '0;
    rob_tail       = '0;
    cdb_valid      = 1'b0;
    cdb_tag        = '0;
    retire_valid   = 1'b0;
    retire_told    = '0;
    rollback_valid = 1'b0;
    rollback_tag   = '0;
    build_table();
    repeat (5) @(posedge clock);  // reset seen on 5 edges
    reset <= 1'b0;
    foreach (steps[k]) begin
      @(posedge clock);
      apply_row(steps[k]);
      @(negedge clock);  // outputs settled mid-cycle
      step_errs = 0;
      check_row(steps[k]);
      if (step_errs == 0) begin
        $display("step %0d: ok", k);
      end else begin
        $display("step %0d: %0d mismatches", k, step_errs);
      end
    end
    @(posedge clock);  // assertions sample the last step here
    @(negedge clock);  // their action blocks have run by now
    $display("steps %0d, checks %0d, errors %0d, assertion failures %0d",
             steps.size(), checks, errors, rename_stage_inst.checker_inst.fails);
    if (errors == 0 && rename_stage_inst.checker_inst.fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+logic
logic/rename_pkg.sv
logic/map_port_if.sv
logic/map_table.sv
logic/free_list.sv
logic/rename_dispatch.sv
logic/rename_stage.sv
dv/rename_stage_checker.sv
dv/rename_stage_tb.sv

//--- Bender.yml
package:
  name: rename_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/rename_pkg.sv
      - logic/map_port_if.sv
      - logic/map_table.sv
      - logic/free_list.sv
      - logic/rename_dispatch.sv
      - logic/rename_stage.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/rename_stage_checker.sv
      - dv/rename_stage_tb.sv
